/* nebula_settings.svh */
// ##########################################################
// Nebula user area parameters
// ##########################################################

`ifndef NEBULA_SETTINGS_SVH
`define NEBULA_SETTINGS_SVH

// Team slots and pad widths
`define NEBULA_NUM_TEAMS 2
`define NEBULA_IO_W 38
`define NEBULA_LA_W 128
`define NEBULA_LA_BANKS 4 // 32-bit LA banks

`define NEBULA_SRAM_AW 8 // Word address bits, 256 words

// Address map, region field sits at bits 19:16
`define NEBULA_REGION_LSB 16
`define NEBULA_REGION_W 4
`define NEBULA_REGION_SRAM 0
`define NEBULA_REGION_SEL 1
`define NEBULA_REGION_TEAM1 2
`define NEBULA_REGION_TEAM2 3 // Highest mapped region

`endif

/* nebula_pkg.sv */
// ##########################################################
// Nebula bus and I/O types
// ##########################################################

`include "nebula_settings.svh"

package nebula_pkg;

    // Wishbone fields
    typedef logic [31:0] wb_addr_t; // Byte address
    typedef logic [31:0] wb_data_t;
    typedef logic [3:0]  wb_sel_t;  // One bit per byte lane

    // Manager to target
    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_sel_t  sel;
        wb_addr_t adr;
        wb_data_t dat;
    } wb_req_t;

    // Target to manager
    typedef struct packed {
        logic     ack;
        wb_data_t dat;
    } wb_rsp_t;

    typedef logic [`NEBULA_IO_W-1:0] gpio_vec_t;

    // Everything one team drives toward the pads
    typedef struct packed {
        gpio_vec_t               gpio_out;
        gpio_vec_t               gpio_oeb; // Active low enable
        logic [`NEBULA_LA_W-1:0] la_out;
    } team_io_t;

    // 0 and 3 select the default, 1 and 2 pick a team
    typedef logic [1:0] team_sel_t;

    typedef logic [31:0] la_bank_t;

endpackage

/* wb_decoder.sv */
// ##########################################################
// Wishbone address decoder
// ##########################################################

`timescale 1ns/10ps

`include "nebula_settings.svh"

module wb_decoder (
    input  logic                                          wb_clk_i,
    input  logic                                          reset_i,
    input  nebula_pkg::wb_req_t                           req_i,
    output nebula_pkg::wb_rsp_t                           rsp_o,
    output nebula_pkg::wb_req_t [`NEBULA_REGION_TEAM2:0]  tgt_req_o,
    input  nebula_pkg::wb_rsp_t [`NEBULA_REGION_TEAM2:0]  tgt_rsp_i
);

    localparam int NUM_REGIONS = `NEBULA_REGION_TEAM2 + 1;
    localparam int IDX_W = $clog2(NUM_REGIONS);

    logic [`NEBULA_REGION_W-1:0] region;
    logic [IDX_W-1:0]            region_idx;
    logic                        mapped;
    logic                        miss_ack_q; // Ack for unmapped regions

    assign region     = req_i.adr[`NEBULA_REGION_LSB +: `NEBULA_REGION_W];
    assign region_idx = region[IDX_W-1:0];
    assign mapped     = (region < NUM_REGIONS);

    // Every target sees the full request, only the addressed one gets cyc and stb
    always_comb begin
        for (int r = 0; r < NUM_REGIONS; r++) begin
            tgt_req_o[r]     = req_i;
            tgt_req_o[r].cyc = req_i.cyc & mapped & (region_idx == IDX_W'(r));
            tgt_req_o[r].stb = req_i.stb & mapped & (region_idx == IDX_W'(r));
        end
    end

    // Response path stays combinational
    always_comb begin
        if (mapped) begin
            rsp_o = tgt_rsp_i[region_idx];
        end else begin
            rsp_o.ack = miss_ack_q;
            rsp_o.dat = '0; // Unmapped reads return zero
        end
    end

    // One-cycle ack so a stray access never hangs the bus
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            miss_ack_q <= 1'b0;
        end else begin
            miss_ack_q <= req_i.cyc & req_i.stb & ~mapped & ~miss_ack_q;
        end
    end

endmodule

/* io_select_regs.sv */
// ##########################################################
// GPIO and LA team select registers
// ##########################################################

`timescale 1ns/10ps

`include "nebula_settings.svh"

module io_select_regs (
    input  logic                                         wb_clk_i,
    input  logic                                         reset_i,
    input  nebula_pkg::wb_req_t                          req_i,
    output nebula_pkg::wb_rsp_t                          rsp_o,
    output nebula_pkg::team_sel_t [`NEBULA_IO_W-1:0]     gpio_sel_o,
    output nebula_pkg::team_sel_t [`NEBULA_LA_BANKS-1:0] la_sel_o
);

    localparam int PINS_PER_WORD = 16;
    localparam int GPIO_WORDS = (`NEBULA_IO_W + PINS_PER_WORD - 1) / PINS_PER_WORD;
    localparam int LA_WORD = GPIO_WORDS; // LA selects follow the GPIO words
    localparam int NUM_WORDS = GPIO_WORDS + 1;
    localparam int OFF_W = `NEBULA_REGION_LSB - 2;
    localparam int WORD_IDX_W = $clog2(NUM_WORDS);

    nebula_pkg::team_sel_t [`NEBULA_IO_W-1:0]     gpio_sel_q;
    nebula_pkg::team_sel_t [`NEBULA_LA_BANKS-1:0] la_sel_q;
    nebula_pkg::wb_data_t                         words [NUM_WORDS];
    nebula_pkg::wb_data_t                         rdata_q;
    logic [OFF_W-1:0]                             offset;
    logic                                         access;
    logic                                         ack_q;

    assign offset = req_i.adr[2 +: OFF_W];
    assign access = req_i.cyc & req_i.stb & ~ack_q; // Blocked while ack is up

    // Readback view, unused bits stay zero
    always_comb begin
        for (int w = 0; w < NUM_WORDS; w++) begin
            words[w] = '0;
        end
        for (int n = 0; n < `NEBULA_IO_W; n++) begin
            words[n / PINS_PER_WORD][2 * (n % PINS_PER_WORD) +: 2] = gpio_sel_q[n];
        end
        for (int b = 0; b < `NEBULA_LA_BANKS; b++) begin
            words[LA_WORD][2 * b +: 2] = la_sel_q[b];
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            ack_q      <= 1'b0;
            gpio_sel_q <= '0;
            la_sel_q   <= '0;
        end else begin
            ack_q <= access;
            if (access && req_i.we) begin
                // A 2-bit field never straddles a byte lane
                for (int n = 0; n < `NEBULA_IO_W; n++) begin
                    if (offset == OFF_W'(n / PINS_PER_WORD) &&
                        req_i.sel[(n % PINS_PER_WORD) / 4]) begin
                        gpio_sel_q[n] <= req_i.dat[2 * (n % PINS_PER_WORD) +: 2];
                    end
                end
                for (int b = 0; b < `NEBULA_LA_BANKS; b++) begin
                    if (offset == OFF_W'(LA_WORD) && req_i.sel[b / 4]) begin
                        la_sel_q[b] <= req_i.dat[2 * b +: 2];
                    end
                end
            end
        end
    end

    // Read data lands together with ack
    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            rdata_q <= (offset < NUM_WORDS) ? words[offset[WORD_IDX_W-1:0]] : '0;
        end
    end

    assign rsp_o.ack  = ack_q;
    assign rsp_o.dat  = rdata_q;
    assign gpio_sel_o = gpio_sel_q;
    assign la_sel_o   = la_sel_q;

endmodule

/* io_output_mux.sv */
// ##########################################################
// Team to pad output routing
// ##########################################################

`timescale 1ns/10ps

`include "nebula_settings.svh"

module io_output_mux (
    input  nebula_pkg::team_io_t  [`NEBULA_NUM_TEAMS-1:0] teams_i,
    input  nebula_pkg::team_sel_t [`NEBULA_IO_W-1:0]      gpio_sel_i,
    input  nebula_pkg::team_sel_t [`NEBULA_LA_BANKS-1:0]  la_sel_i,
    output nebula_pkg::gpio_vec_t                         io_out_o,
    output nebula_pkg::gpio_vec_t                         io_oeb_o,
    output logic [`NEBULA_LA_W-1:0]                       la_data_out_o
);

    localparam int BANK_W = $bits(nebula_pkg::la_bank_t);

    // Select value t+1 picks team t, anything else keeps the default
    always_comb begin
        io_out_o = '0;
        io_oeb_o = '1; // Unrouted pins stay tristated
        for (int n = 0; n < `NEBULA_IO_W; n++) begin
            for (int t = 0; t < `NEBULA_NUM_TEAMS; t++) begin
                if (gpio_sel_i[n] == nebula_pkg::team_sel_t'(t + 1)) begin
                    io_out_o[n] = teams_i[t].gpio_out[n];
                    io_oeb_o[n] = teams_i[t].gpio_oeb[n];
                end
            end
        end
    end

    // Whole banks move together
    always_comb begin
        la_data_out_o = '0;
        for (int b = 0; b < `NEBULA_LA_BANKS; b++) begin
            for (int t = 0; t < `NEBULA_NUM_TEAMS; t++) begin
                if (la_sel_i[b] == nebula_pkg::team_sel_t'(t + 1)) begin
                    la_data_out_o[b * BANK_W +: BANK_W] =
                        teams_i[t].la_out[b * BANK_W +: BANK_W];
                end
            end
        end
    end

endmodule

/* word_sram.sv */
// ##########################################################
// Wishbone word SRAM
// ##########################################################

`timescale 1ns/10ps

`include "nebula_settings.svh"

module word_sram (
    input  logic                wb_clk_i,
    input  logic                reset_i,
    input  nebula_pkg::wb_req_t req_i,
    output nebula_pkg::wb_rsp_t rsp_o
);

    localparam int DEPTH = 1 << `NEBULA_SRAM_AW;

    nebula_pkg::wb_data_t       mem [DEPTH];
    nebula_pkg::wb_data_t       rdata_q;
    logic [`NEBULA_SRAM_AW-1:0] word_addr;
    logic                       access;
    logic                       ack_q;

    assign word_addr = req_i.adr[2 +: `NEBULA_SRAM_AW]; // Upper offset bits alias
    assign access    = req_i.cyc & req_i.stb & ~ack_q;

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    // Byte-lane writes, full-word reads
    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            if (req_i.we) begin
                for (int l = 0; l < $bits(nebula_pkg::wb_sel_t); l++) begin
                    if (req_i.sel[l]) mem[word_addr][8 * l +: 8] <= req_i.dat[8 * l +: 8];
                end
            end
            rdata_q <= mem[word_addr];
        end
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = rdata_q;

endmodule

/* team_counter.sv */
// ##########################################################
// Sample team design, loadable counter
// ##########################################################

`timescale 1ns/10ps

`include "nebula_settings.svh"

module team_counter (
    input  logic                    wb_clk_i,
    input  logic                    reset_i,
    input  nebula_pkg::wb_req_t     req_i,
    output nebula_pkg::wb_rsp_t     rsp_o,
    input  logic [`NEBULA_LA_W-1:0] la_data_in_i,
    output nebula_pkg::team_io_t    team_o
);

    localparam int OFF_W = `NEBULA_REGION_LSB - 2;
    localparam logic [OFF_W-1:0] OFF_CTRL = OFF_W'(0);
    localparam logic [OFF_W-1:0] OFF_COUNT = OFF_W'(1);
    localparam logic [OFF_W-1:0] OFF_SAMPLE = OFF_W'(2);

    logic [OFF_W-1:0]     offset;
    logic                 access;
    logic                 wr;
    logic                 ack_q;
    logic [1:0]           ctrl_q; // Bit 0 count enable, bit 1 pin enable
    nebula_pkg::wb_data_t count_q;
    nebula_pkg::wb_data_t count_nxt;
    nebula_pkg::wb_data_t rdata_q;
    nebula_pkg::la_bank_t la_samp_q;

    assign offset = req_i.adr[2 +: OFF_W];
    assign access = req_i.cyc & req_i.stb & ~ack_q;
    assign wr     = access & req_i.we;

    // Bus write wins over the increment, lane by lane
    always_comb begin
        count_nxt = count_q + nebula_pkg::wb_data_t'(ctrl_q[0]);
        if (wr && offset == OFF_COUNT) begin
            for (int l = 0; l < $bits(nebula_pkg::wb_sel_t); l++) begin
                if (req_i.sel[l]) count_nxt[8 * l +: 8] = req_i.dat[8 * l +: 8];
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            ack_q   <= 1'b0;
            ctrl_q  <= '0;
            count_q <= '0;
        end else begin
            ack_q   <= access;
            count_q <= count_nxt;
            if (wr && offset == OFF_CTRL && req_i.sel[0]) ctrl_q <= req_i.dat[1:0];
        end
    end

    always_ff @(posedge wb_clk_i) begin
        la_samp_q <= la_data_in_i[$bits(nebula_pkg::la_bank_t)-1:0]; // Lowest LA bank
        if (access) begin
            case (offset)
                OFF_CTRL:   rdata_q <= nebula_pkg::wb_data_t'(ctrl_q);
                OFF_COUNT:  rdata_q <= count_q;
                OFF_SAMPLE: rdata_q <= la_samp_q;
                default:    rdata_q <= '0;
            endcase
        end
    end

    assign rsp_o.ack       = ack_q;
    assign rsp_o.dat       = rdata_q;
    assign team_o.gpio_out = nebula_pkg::gpio_vec_t'(count_q); // Upper pins read 0
    assign team_o.gpio_oeb = {`NEBULA_IO_W{~ctrl_q[1]}};
    assign team_o.la_out   = {`NEBULA_LA_BANKS{count_q}}; // Count on every bank

endmodule

/* nebula_top.sv */
// ##########################################################
// Nebula user area top level
// ##########################################################

`timescale 1ns/10ps

`include "nebula_settings.svh"

module nebula_top (
    input  logic                    wb_clk_i,
    input  logic                    reset_i,

    // Wishbone target port from the management SoC
    input  logic                    wbs_stb_i,
    input  logic                    wbs_cyc_i,
    input  logic                    wbs_we_i,
    input  nebula_pkg::wb_sel_t     wbs_sel_i,
    input  nebula_pkg::wb_data_t    wbs_dat_i,
    input  nebula_pkg::wb_addr_t    wbs_adr_i,
    output logic                    wbs_ack_o,
    output nebula_pkg::wb_data_t    wbs_dat_o,

    // Logic analyzer
    input  logic [`NEBULA_LA_W-1:0] la_data_in_i,
    output logic [`NEBULA_LA_W-1:0] la_data_out_o,

    // Pads
    input  nebula_pkg::gpio_vec_t   io_in_i, // Pad compatibility only
    output nebula_pkg::gpio_vec_t   io_out_o,
    output nebula_pkg::gpio_vec_t   io_oeb_o
);

    nebula_pkg::wb_req_t                                 wb_req;
    nebula_pkg::wb_rsp_t                                 wb_rsp;
    nebula_pkg::wb_req_t   [`NEBULA_REGION_TEAM2:0]      tgt_req;
    nebula_pkg::wb_rsp_t   [`NEBULA_REGION_TEAM2:0]      tgt_rsp;
    nebula_pkg::team_io_t  [`NEBULA_NUM_TEAMS-1:0]       teams;
    nebula_pkg::team_sel_t [`NEBULA_IO_W-1:0]            gpio_sel;
    nebula_pkg::team_sel_t [`NEBULA_LA_BANKS-1:0]        la_sel;

    // Discrete Caravel signals into one request
    assign wb_req.cyc = wbs_cyc_i;
    assign wb_req.stb = wbs_stb_i;
    assign wb_req.we  = wbs_we_i;
    assign wb_req.sel = wbs_sel_i;
    assign wb_req.adr = wbs_adr_i;
    assign wb_req.dat = wbs_dat_i;
    assign wbs_ack_o  = wb_rsp.ack;
    assign wbs_dat_o  = wb_rsp.dat;

    wb_decoder u_decoder (
        .wb_clk_i(wb_clk_i), .reset_i(reset_i),
        .req_i(wb_req), .rsp_o(wb_rsp),
        .tgt_req_o(tgt_req), .tgt_rsp_i(tgt_rsp)
    );

    word_sram u_sram (
        .wb_clk_i(wb_clk_i), .reset_i(reset_i),
        .req_i(tgt_req[`NEBULA_REGION_SRAM]), .rsp_o(tgt_rsp[`NEBULA_REGION_SRAM])
    );

    io_select_regs u_sel_regs (
        .wb_clk_i(wb_clk_i), .reset_i(reset_i),
        .req_i(tgt_req[`NEBULA_REGION_SEL]), .rsp_o(tgt_rsp[`NEBULA_REGION_SEL]),
        .gpio_sel_o(gpio_sel), .la_sel_o(la_sel)
    );

    // Select value 1 maps to teams[0], value 2 to teams[1]
    team_counter u_team1 (
        .wb_clk_i(wb_clk_i), .reset_i(reset_i),
        .req_i(tgt_req[`NEBULA_REGION_TEAM1]), .rsp_o(tgt_rsp[`NEBULA_REGION_TEAM1]),
        .la_data_in_i(la_data_in_i), .team_o(teams[0])
    );

    team_counter u_team2 (
        .wb_clk_i(wb_clk_i), .reset_i(reset_i),
        .req_i(tgt_req[`NEBULA_REGION_TEAM2]), .rsp_o(tgt_rsp[`NEBULA_REGION_TEAM2]),
        .la_data_in_i(la_data_in_i), .team_o(teams[1])
    );

    io_output_mux u_mux (
        .teams_i(teams), .gpio_sel_i(gpio_sel), .la_sel_i(la_sel),
        .io_out_o(io_out_o), .io_oeb_o(io_oeb_o), .la_data_out_o(la_data_out_o)
    );

endmodule

/* tb_nebula.sv */
// ##########################################################
// Nebula user area testbench
// ##########################################################

`timescale 1ns/10ps

`include "nebula_settings.svh"

module tb_nebula;

    localparam int ACK_TIMEOUT = 16;
    localparam int SLOTS = 16; // SRAM words under test

    logic                    wb_clk = 1'b0;
    logic                    reset;
    logic                    wbs_cyc;
    logic                    wbs_stb;
    logic                    wbs_we;
    nebula_pkg::wb_sel_t     wbs_sel;
    nebula_pkg::wb_data_t    wbs_wdat;
    nebula_pkg::wb_addr_t    wbs_adr;
    logic                    wbs_ack;
    nebula_pkg::wb_data_t    wbs_rdat;
    logic [`NEBULA_LA_W-1:0] la_in;
    logic [`NEBULA_LA_W-1:0] la_out;
    nebula_pkg::gpio_vec_t   io_in;
    nebula_pkg::gpio_vec_t   io_out;
    nebula_pkg::gpio_vec_t   io_oeb;

    // Reference models
    nebula_pkg::wb_data_t       ref_mem [1 << `NEBULA_SRAM_AW];
    logic [`NEBULA_SRAM_AW-1:0] slot_addr [SLOTS];
    nebula_pkg::team_sel_t      gpio_sel_m [`NEBULA_IO_W];
    nebula_pkg::team_sel_t      la_sel_m [`NEBULA_LA_BANKS];
    nebula_pkg::wb_data_t       team_count [`NEBULA_NUM_TEAMS]; // Counting stays off
    logic                       team_oe [`NEBULA_NUM_TEAMS];    // Ctrl bit 1
    logic [31:0]                lcg_state;

    nebula_top dut0 (
        .wb_clk_i(wb_clk), .reset_i(reset), .wbs_stb_i(wbs_stb), .wbs_cyc_i(wbs_cyc),
        .wbs_we_i(wbs_we), .wbs_sel_i(wbs_sel), .wbs_dat_i(wbs_wdat), .wbs_adr_i(wbs_adr),
        .wbs_ack_o(wbs_ack), .wbs_dat_o(wbs_rdat), .la_data_in_i(la_in),
        .la_data_out_o(la_out), .io_in_i(io_in), .io_out_o(io_out), .io_oeb_o(io_oeb)
    );

    always #10 wb_clk = ~wb_clk;

    // Consecutive values of a full-period LCG never repeat
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic nebula_pkg::wb_addr_t make_addr(int region, int word);
        return (32'(region) << `NEBULA_REGION_LSB) | (32'(word) << 2);
    endfunction

    task automatic stop_run();
        $display(">>> FAIL");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_data(string name, nebula_pkg::wb_data_t got,
                              nebula_pkg::wb_data_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_gpio(string name, nebula_pkg::gpio_vec_t got,
                              nebula_pkg::gpio_vec_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_la(string name, logic [`NEBULA_LA_W-1:0] got,
                            logic [`NEBULA_LA_W-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_ack(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    // Classic cycle holds the request until ack shows on a falling edge
    task automatic wb_access(input logic we, input nebula_pkg::wb_addr_t adr,
                             input nebula_pkg::wb_data_t dat, input nebula_pkg::wb_sel_t sel,
                             output nebula_pkg::wb_data_t rdata);
        int cycles;
        @(negedge wb_clk);
        check_ack("wbs_ack_o while idle", wbs_ack, 1'b0); // Ack lasts one cycle
        {wbs_cyc, wbs_stb, wbs_we} = {2'b11, we};
        wbs_sel  = sel;
        wbs_adr  = adr;
        wbs_wdat = dat;
        cycles   = 0;
        do begin
            @(negedge wb_clk);
            cycles++;
            if (cycles > ACK_TIMEOUT) begin
                $display("Timeout: no Wishbone ack for address %h at %0t", adr, $time);
                stop_run();
            end
        end while (wbs_ack !== 1'b1);
        rdata = wbs_rdat;
        {wbs_cyc, wbs_stb, wbs_we} = 3'b000;
    endtask

    task automatic wb_write(nebula_pkg::wb_addr_t adr, nebula_pkg::wb_data_t dat,
                            nebula_pkg::wb_sel_t sel);
        nebula_pkg::wb_data_t unused;
        wb_access(1'b1, adr, dat, sel, unused);
    endtask

    task automatic wb_read(input nebula_pkg::wb_addr_t adr, output nebula_pkg::wb_data_t rdata);
        wb_access(1'b0, adr, '0, 4'hf, rdata);
    endtask

    task automatic sram_write(logic [`NEBULA_SRAM_AW-1:0] waddr, nebula_pkg::wb_data_t dat,
                              nebula_pkg::wb_sel_t sel);
        for (int l = 0; l < 4; l++) begin
            if (sel[l]) ref_mem[waddr][8 * l +: 8] = dat[8 * l +: 8];
        end
        wb_write(make_addr(`NEBULA_REGION_SRAM, waddr), dat, sel);
    endtask

    // Pin n lives in word n/16 at bit 2*(n%16) and LA banks in word 3
    function automatic nebula_pkg::wb_data_t sel_word(int w);
        nebula_pkg::wb_data_t word;
        word = '0;
        for (int n = 0; n < `NEBULA_IO_W; n++) begin
            if (n / 16 == w) word[2 * (n % 16) +: 2] = gpio_sel_m[n];
        end
        for (int b = 0; b < `NEBULA_LA_BANKS; b++) begin
            if (w == 3) word[2 * b +: 2] = la_sel_m[b];
        end
        return word;
    endfunction

    task automatic sel_write(int w, nebula_pkg::wb_data_t dat, nebula_pkg::wb_sel_t sel);
        for (int n = 0; n < `NEBULA_IO_W; n++) begin
            if (n / 16 == w && sel[(n % 16) / 4]) gpio_sel_m[n] = dat[2 * (n % 16) +: 2];
        end
        for (int b = 0; b < `NEBULA_LA_BANKS; b++) begin
            if (w == 3 && sel[b / 4]) la_sel_m[b] = dat[2 * b +: 2];
        end
        wb_write(make_addr(`NEBULA_REGION_SEL, w), dat, sel);
    endtask

    task automatic check_outputs();
        nebula_pkg::gpio_vec_t   exp_out;
        nebula_pkg::gpio_vec_t   exp_oeb;
        nebula_pkg::gpio_vec_t   pins;
        logic [`NEBULA_LA_W-1:0] exp_la;
        exp_out = '0;
        exp_oeb = '1;
        exp_la  = '0;
        for (int n = 0; n < `NEBULA_IO_W; n++) begin
            if (gpio_sel_m[n] == 2'd1 || gpio_sel_m[n] == 2'd2) begin
                pins       = nebula_pkg::gpio_vec_t'(team_count[gpio_sel_m[n] - 1]);
                exp_out[n] = pins[n]; // Pins above 31 read 0
                exp_oeb[n] = ~team_oe[gpio_sel_m[n] - 1];
            end
        end
        for (int b = 0; b < `NEBULA_LA_BANKS; b++) begin
            if (la_sel_m[b] == 2'd1 || la_sel_m[b] == 2'd2)
                exp_la[32 * b +: 32] = team_count[la_sel_m[b] - 1];
        end
        check_gpio("io_out_o", io_out, exp_out);
        check_gpio("io_oeb_o", io_oeb, exp_oeb);
        check_la("la_data_out_o", la_out, exp_la);
    endtask

    initial begin
        nebula_pkg::wb_data_t rdata;
        logic [31:0]          rval;
        lcg_state = 32'd79918;
        reset     = 1'b1;
        {wbs_cyc, wbs_stb, wbs_we} = 3'b000;
        {wbs_sel, wbs_wdat, wbs_adr} = '0;
        la_in = '0;
        io_in = '0;
        gpio_sel_m = '{default: '0};
        la_sel_m   = '{default: '0};
        team_count = '{default: '0};
        team_oe    = '{default: 1'b0};
        repeat (4) @(negedge wb_clk);
        reset = 1'b0;

        @(negedge wb_clk);
        check_outputs();
        for (int w = 0; w < 4; w++) begin
            wb_read(make_addr(`NEBULA_REGION_SEL, w), rdata);
            check_data("wbs_dat_o select word after reset", rdata, 32'h0);
        end

        // Full words first so every lane is known before the partial writes
        for (int i = 0; i < SLOTS; i++) begin
            rval = next_rand();
            slot_addr[i] = rval[23:16];
            sram_write(slot_addr[i], next_rand(), 4'hf);
        end
        for (int i = 0; i < 48; i++) begin
            rval = next_rand();
            sram_write(slot_addr[rval[31:28]], next_rand(), rval[19:16]);
        end
        for (int i = 0; i < SLOTS; i++) begin
            wb_read(make_addr(`NEBULA_REGION_SRAM, slot_addr[i]), rdata);
            check_data($sformatf("wbs_dat_o sram word %0d", slot_addr[i]), rdata,
                       ref_mem[slot_addr[i]]);
        end

        for (int t = 0; t < `NEBULA_NUM_TEAMS; t++) begin
            team_count[t] = next_rand();
            team_oe[t]    = 1'b1;
            wb_write(make_addr(`NEBULA_REGION_TEAM1 + t, 1), team_count[t], 4'hf);
            wb_write(make_addr(`NEBULA_REGION_TEAM1 + t, 0), 32'h2, 4'hf);
            wb_read(make_addr(`NEBULA_REGION_TEAM1 + t, 1), rdata);
            check_data("wbs_dat_o team count", rdata, team_count[t]);
        end

        // GPIO select rounds come before the LA bank rounds
        for (int r = 0; r < 16; r++) begin
            for (int w = (r < 8) ? 0 : 3; w < ((r < 8) ? 3 : 4); w++) begin
                rval = next_rand();
                sel_write(w, next_rand(), rval[27:24]);
            end
            @(negedge wb_clk);
            check_outputs();
            for (int w = 0; w < 4; w++) begin
                wb_read(make_addr(`NEBULA_REGION_SEL, w), rdata);
                check_data($sformatf("wbs_dat_o select word %0d", w), rdata, sel_word(w));
            end
        end

        la_in = {next_rand(), next_rand(), next_rand(), next_rand()};
        for (int t = 0; t < `NEBULA_NUM_TEAMS; t++) begin
            wb_read(make_addr(`NEBULA_REGION_TEAM1 + t, 2), rdata);
            check_data("wbs_dat_o LA sample", rdata, la_in[31:0]);
        end
        for (int i = 0; i < 4; i++) begin
            rval = next_rand();
            wb_read(make_addr(4 + int'(rval[31:28]) % 12, int'(rval[13:0])), rdata);
            check_data("wbs_dat_o unmapped region", rdata, 32'h0);
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

/* sources.f */
+incdir+.
nebula_pkg.sv
wb_decoder.sv
io_select_regs.sv
io_output_mux.sv
word_sram.sv
team_counter.sv
nebula_top.sv
tb_nebula.sv

/* Bender.yml */
package:
  name: nebula

sources:
  - include_dirs:
      - .
    files:
      - nebula_pkg.sv
      - wb_decoder.sv
      - io_select_regs.sv
      - io_output_mux.sv
      - word_sram.sv
      - team_counter.sv
      - nebula_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_nebula.sv
